// ==== files.f ====
source/tims_mem_pkg.sv
source/scratchpad_ram.sv
source/ext_mem_port.sv
source/bus_capture_stage.sv
source/region_decode_stage.sv
source/mem_access_stage.sv
source/tims_mem_top.sv
bench/tb_ext_mem_model.sv
bench/tb_tims_mem.sv

// ==== Bender.yml ====
package:
  name: tims_mem

sources:
  - files:
      - source/tims_mem_pkg.sv
      - source/scratchpad_ram.sv
      - source/ext_mem_port.sv
      - source/bus_capture_stage.sv
      - source/region_decode_stage.sv
      - source/mem_access_stage.sv
      - source/tims_mem_top.sv
  - target: simulation
    files:
      - bench/tb_ext_mem_model.sv
      - bench/tb_tims_mem.sv

// ==== bench/tb_tims_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tims_mem
  import tims_mem_pkg::*;
();

  localparam int unsigned             LCG_SEED     = 9228;
  localparam int                      WAIT_TIMEOUT = 4 * WAIT_LIMIT;
  localparam logic [WORD_ADDR_W-1:0]  DEAD_LO      = 23'h0BC000;  // Paged memory, no answer
  localparam logic [WORD_ADDR_W-1:0]  DEAD_HI      = 23'h0BCFFF;

  // ROM, RAM expansion, GROM, Pi DSR, paged and cartridge words
  localparam logic [WORD_ADDR_W-1:0] EXT_ADDRS [10] = '{
    23'h000123, 23'h001456, 23'h005678, 23'h007ABC, 23'h008123,
    23'h00F000, 23'h01A000, 23'h09ABCD, 23'h123456, 23'h2FFFFF};
  // DSR window and other holes
  localparam logic [WORD_ADDR_W-1:0] NONE_ADDRS [10] = '{
    23'h002000, 23'h002FFF, 23'h003800, 23'h004200, 23'h004FFF,
    23'h010000, 23'h020000, 23'h07FFFF, 23'h300000, 23'h7FFFFF};

  logic               clk = 1'b0;
  logic               i_reset;
  logic               i_cpu_strobe;
  cpu_req_t           i_cpu_req;
  logic               o_cpu_busy;
  logic               o_cpu_done;
  logic               o_cpu_timeout;
  logic [DATA_W-1:0]  o_cpu_rdata;
  logic               o_ext_req;
  ext_req_t           o_ext_req_data;
  logic               i_ext_ack;
  logic [DATA_W-1:0]  i_ext_rdata;
  logic               model_error;

  // Scoreboard state for the access in flight
  string              test_name;
  logic [DATA_W-1:0]  exp_rdata;
  logic               exp_timeout;
  ext_req_t           exp_ext;      // Payload seen off chip
  logic               no_ext;       // Access must stay on chip
  int unsigned        lcg_state;

  always #4 clk = ~clk;

  tims_mem_top u_tims_mem_top (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_cpu_strobe   (i_cpu_strobe),
    .i_cpu_req      (i_cpu_req),
    .o_cpu_busy     (o_cpu_busy),
    .o_cpu_done     (o_cpu_done),
    .o_cpu_timeout  (o_cpu_timeout),
    .o_cpu_rdata    (o_cpu_rdata),
    .o_ext_req      (o_ext_req),
    .o_ext_req_data (o_ext_req_data),
    .i_ext_ack      (i_ext_ack),
    .i_ext_rdata    (i_ext_rdata)
  );

  tb_ext_mem_model #(.SEED(LCG_SEED), .DEAD_LO(DEAD_LO), .DEAD_HI(DEAD_HI)) u_ext_mem_model (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_ext_req      (o_ext_req),
    .i_ext_req_data (o_ext_req_data),
    .o_ext_ack      (i_ext_ack),
    .o_ext_rdata    (i_ext_rdata),
    .o_error        (model_error)
  );

  // ===================================================================
  // Helpers
  // ===================================================================
  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Memory map by word address
  function automatic mem_target_t region_of(input logic [WORD_ADDR_W-1:0] a);
    if (a >= 23'h004000 && a <= 23'h0041FF)
      return TGT_PAD;
    if (a <= 23'h001FFF || (a >= 23'h005000 && a <= 23'h00FFFF))
      return TGT_EXT;                                  // ROM, RAM, GROM
    if ((a >= 23'h018000 && a <= 23'h01FFFF) || (a >= 23'h080000 && a <= 23'h2FFFFF))
      return TGT_EXT;                                  // Pi DSR, paged, carts
    return TGT_NONE;
  endfunction

  function automatic logic [15:0] lane_merge(input logic [15:0] old_d, input logic [15:0] new_d,
                                             input logic [1:0] be);
    return {be[1] ? new_d[15:8] : old_d[15:8], be[0] ? new_d[7:0] : old_d[7:0]};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
    abort_run($sformatf("Fail %s: %s expected %0h actual %0h", test_name, what, exp, act));
  endtask

  // One CPU access, strobe on a falling edge, wait for done
  task automatic cpu_access(input logic [WORD_ADDR_W-1:0] a, input logic [15:0] wdata,
                            input logic we, input logic [1:0] be,
                            input logic [15:0] exp_d, input logic exp_to);
    int           cycles;
    int           req_cycle;
    mem_target_t  tgt;
    tgt = region_of(a);
    @(negedge clk);
    exp_rdata    = exp_d;
    exp_timeout  = exp_to;
    exp_ext      = '{addr: a, wdata: wdata, we: we, be: be};  // Address unchanged off chip
    no_ext       = (tgt != TGT_EXT);
    i_cpu_req    = '{addr: a, wdata: wdata, we: we, be: be};
    i_cpu_strobe = 1'b1;
    @(negedge clk);
    i_cpu_strobe = 1'b0;
    cycles       = 0;
    req_cycle    = -1;
    while (!o_cpu_done)
    begin
      @(negedge clk);
      cycles++;
      if (o_ext_req && req_cycle < 0)
        req_cycle = cycles;   // Request first seen
      if (cycles > WAIT_TIMEOUT)
        abort_run("CPU access did not complete in time");
    end
    if (tgt != TGT_EXT)
      assert (cycles == 3) else report_mismatch("latency", 3, cycles);
    if (exp_to)
      assert (req_cycle >= 0 && cycles - req_cycle >= WAIT_LIMIT
              && cycles - req_cycle <= WAIT_LIMIT + 2)
        else report_mismatch("timeout delay", WAIT_LIMIT, cycles - req_cycle);
  endtask

  task automatic write_word(input logic [WORD_ADDR_W-1:0] a, input logic [15:0] d,
                            input logic [1:0] be);
    cpu_access(a, d, 1'b1, be, 16'h0000, 1'b0);  // Writes answer zero
  endtask

  task automatic read_word(input logic [WORD_ADDR_W-1:0] a, input logic [15:0] exp_d);
    cpu_access(a, 16'h0000, 1'b0, 2'b11, exp_d, 1'b0);
  endtask

  // ===================================================================
  // Protocol and result checks
  // ===================================================================
  assert property (@(posedge clk) disable iff (i_reset) $rose(o_ext_req) |-> !$past(i_ext_ack))
    else abort_run("external request rose while ack was still high");
  assert property (@(posedge clk) disable iff (i_reset)
                   $fell(o_ext_req) |-> $past(i_ext_ack) || exp_timeout)
    else abort_run("external request dropped before ack");
  assert property (@(posedge clk) disable iff (i_reset) $fell(i_ext_ack) |-> !o_ext_req)
    else abort_run("ack fell while the request was still high");
  assert property (@(posedge clk) disable iff (i_reset)
                   o_ext_req |-> o_ext_req_data == exp_ext)
    else report_mismatch("request payload", exp_ext, $sampled(o_ext_req_data));
  assert property (@(posedge clk) disable iff (i_reset) no_ext |-> !o_ext_req)
    else abort_run("external request for an on-chip or unmapped access");
  assert property (@(posedge clk) disable iff (i_reset) $fell(o_cpu_busy) |-> o_cpu_done)
    else abort_run("busy fell without done");
  assert property (@(posedge clk) disable iff (i_reset) o_cpu_done |-> $fell(o_cpu_busy))
    else abort_run("done rose while busy did not fall");
  assert property (@(posedge clk) disable iff (i_reset) o_cpu_timeout |-> o_cpu_done)
    else abort_run("timeout flag without done");
  assert property (@(posedge clk) disable iff (i_reset) o_cpu_done |-> o_cpu_rdata == exp_rdata)
    else report_mismatch("rdata", exp_rdata, $sampled(o_cpu_rdata));
  assert property (@(posedge clk) disable iff (i_reset)
                   o_cpu_done |-> o_cpu_timeout == exp_timeout)
    else report_mismatch("timeout flag", exp_timeout, $sampled(o_cpu_timeout));
  assert property (@(posedge clk) !model_error)
    else abort_run("external memory saw the request stay high after ack");

  // ===================================================================
  // Stimulus
  // ===================================================================
  initial
  begin
    logic [WORD_ADDR_W-1:0]  a;
    logic [31:0]             rnd;
    logic [15:0]             d0;
    logic [15:0]             d1;
    logic [1:0]              be;
    int                      k;
    i_reset      = 1'b1;
    i_cpu_strobe = 1'b0;
    i_cpu_req    = '0;
    exp_rdata    = '0;
    exp_timeout  = 1'b0;
    exp_ext      = '0;
    no_ext       = 1'b1;
    lcg_state    = LCG_SEED;
    test_name    = "reset";
    repeat (10) @(negedge clk);
    i_reset = 1'b0;
    @(negedge clk);
    assert ({o_cpu_busy, o_cpu_done, o_cpu_timeout, o_ext_req} == 4'b0000)
      else report_mismatch("outputs", 0, {o_cpu_busy, o_cpu_done, o_cpu_timeout, o_ext_req});

    test_name = "scratchpad";  // Every lane mask over a known word
    for (k = 0; k < 4; k++)
    begin
      a = 23'h004000 + 23'(k * 37);
      write_word(a, 16'h3C00 + 16'(k), 2'b11);
      write_word(a, 16'hA5C3 ^ 16'(k << 4), 2'(k));
      read_word(a, lane_merge(16'h3C00 + 16'(k), 16'hA5C3 ^ 16'(k << 4), 2'(k)));
    end
    write_word(23'h0041FF, 16'h7E81, 2'b11);
    read_word(23'h0041FF, 16'h7E81);

    test_name = "external";
    for (k = 0; k < 10; k++)
    begin
      write_word(EXT_ADDRS[k], 16'h1357 + 16'(k), 2'b11);
      write_word(EXT_ADDRS[k], 16'hFEDC, 2'(k));
      read_word(EXT_ADDRS[k], lane_merge(16'h1357 + 16'(k), 16'hFEDC, 2'(k)));
    end

    test_name = "unmapped";
    for (k = 0; k < 10; k++)
      read_word(NONE_ADDRS[k], 16'h0000);
    write_word(23'h004010, 16'hBEEF, 2'b11);
    write_word(23'h002010, 16'h1111, 2'b11);  // Same low 9 bits as the pad word
    write_word(23'h004210, 16'h2222, 2'b11);
    read_word(23'h004010, 16'hBEEF);

    test_name = "timeout";
    cpu_access(DEAD_LO + 23'h123, 16'h0000, 1'b0, 2'b11, 16'h0000, 1'b1);
    write_word(23'h000200, 16'h5A5A, 2'b11);
    read_word(23'h000200, 16'h5A5A);

    test_name = "random";
    for (k = 0; k < 48; k++)
    begin
      rnd = lcg_next();
      case ((rnd >> 16) % 6)
        0:       a = 23'h004000 + 23'(rnd[24:16]);
        1:       a = 23'(rnd[28:16]);
        2:       a = 23'h005000 + 23'(rnd[29:16]);
        3:       a = 23'h080000 + 23'(rnd[31:11]);
        4:       a = 23'h002000 + 23'(rnd[28:16]);
        default: a = rnd[31:9];
      endcase
      if (a >= DEAD_LO && a <= DEAD_HI)
        a[22] = 1'b1;  // Keep clear of the silent window
      rnd = lcg_next();
      d0  = rnd[31:16];
      rnd = lcg_next();
      d1  = rnd[31:16];
      be  = rnd[15:14];
      write_word(a, d0, 2'b11);
      write_word(a, d1, be);
      read_word(a, (region_of(a) == TGT_NONE) ? 16'h0000 : lane_merge(d0, d1, be));
    end

    repeat (4) @(negedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/tb_ext_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ext_mem_model
  import tims_mem_pkg::*;
#(
  parameter int unsigned             SEED    = 1,
  parameter logic [WORD_ADDR_W-1:0]  DEAD_LO = '0,  // No answer inside this range
  parameter logic [WORD_ADDR_W-1:0]  DEAD_HI = '0
)
(
  input  wire                clk,
  input  wire                i_reset,
  input  wire                i_ext_req,
  input  ext_req_t           i_ext_req_data,
  output logic               o_ext_ack,
  output logic [DATA_W-1:0]  o_ext_rdata,
  output logic               o_error       // Request never dropped after ack
);

  logic [DATA_W-1:0] mem [logic [WORD_ADDR_W-1:0]];  // Sparse word store
  int unsigned       r_seed;

  // Unwritten words read back as a pattern of the full address
  function automatic logic [DATA_W-1:0] fill_word(input logic [WORD_ADDR_W-1:0] a);
    return a[15:0] ^ {a[22:16], a[22:16], 2'b10};
  endfunction

  // Answer delay of 1 to 8 cycles
  function int unsigned next_delay();
    r_seed = r_seed * 32'd1664525 + 32'd1013904223;
    return 1 + ((r_seed >> 16) % 8);
  endfunction

  initial
  begin
    r_seed      = SEED;
    o_ext_ack   = 1'b0;
    o_ext_rdata = '0;
    o_error     = 1'b0;
  end

  // ===================================================================
  // Four-phase slave, driven on the falling edge
  // ===================================================================
  always
  begin : answer
    int unsigned        delay;
    int                 guard;
    ext_req_t           rq;
    logic [DATA_W-1:0]  word;
    @(negedge clk);
    rq = i_ext_req_data;
    if (!i_reset && i_ext_req && !(rq.addr >= DEAD_LO && rq.addr <= DEAD_HI))
    begin
      delay = next_delay();
      repeat (delay - 1) @(negedge clk);
      word        = mem.exists(rq.addr) ? mem[rq.addr] : fill_word(rq.addr);
      o_ext_rdata = word;  // Old word on writes too
      if (rq.we)
        mem[rq.addr] = {rq.be[1] ? rq.wdata[15:8] : word[15:8],
                        rq.be[0] ? rq.wdata[7:0]  : word[7:0]};
      o_ext_ack = 1'b1;   // Phase 2
      guard     = 0;
      do
      begin
        @(negedge clk);
        guard++;
      end
      while (i_ext_req && guard < 32);
      if (i_ext_req)
        o_error = 1'b1;
      delay = next_delay();
      repeat (delay - 1) @(negedge clk);  // Slow release of ack
      o_ext_ack = 1'b0;   // Phase 4
    end
  end

endmodule

`default_nettype wire

// ==== source/tims_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tims_mem_top
  import tims_mem_pkg::*;
(
  input  wire                clk,
  input  wire                i_reset,
  // CPU strobe-and-busy side
  input  wire                i_cpu_strobe,
  input  cpu_req_t           i_cpu_req,
  output logic               o_cpu_busy,
  output logic               o_cpu_done,
  output logic               o_cpu_timeout,
  output logic [DATA_W-1:0]  o_cpu_rdata,
  // External memory, four-phase req/ack
  output logic               o_ext_req,
  output ext_req_t           o_ext_req_data,
  input  wire                i_ext_ack,
  input  wire [DATA_W-1:0]   i_ext_rdata
);

  logic               cap_valid;
  cpu_req_t           cap_req;
  logic               dec_valid;
  decoded_req_t       dec_dreq;
  logic               acc_done;
  logic [DATA_W-1:0]  acc_rdata;
  logic               acc_timeout;

  // ===================================================================
  // Capture -> decode -> access, one access in flight
  // ===================================================================
  bus_capture_stage u_bus_capture_stage (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_cpu_strobe  (i_cpu_strobe),
    .i_cpu_req     (i_cpu_req),
    .i_done        (acc_done),
    .i_rdata       (acc_rdata),
    .i_timeout     (acc_timeout),
    .o_valid       (cap_valid),
    .o_req         (cap_req),
    .o_cpu_busy    (o_cpu_busy),
    .o_cpu_done    (o_cpu_done),
    .o_cpu_rdata   (o_cpu_rdata),
    .o_cpu_timeout (o_cpu_timeout)
  );

  region_decode_stage u_region_decode_stage (
    .clk     (clk),
    .i_reset (i_reset),
    .i_valid (cap_valid),
    .i_req   (cap_req),
    .o_valid (dec_valid),
    .o_dreq  (dec_dreq)
  );

  mem_access_stage u_mem_access_stage (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_valid        (dec_valid),
    .i_dreq         (dec_dreq),
    .o_ext_req      (o_ext_req),
    .o_ext_req_data (o_ext_req_data),
    .i_ext_ack      (i_ext_ack),
    .i_ext_rdata    (i_ext_rdata),
    .o_done         (acc_done),
    .o_rdata        (acc_rdata),
    .o_timeout      (acc_timeout)
  );

endmodule

`default_nettype wire

// ==== source/mem_access_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_stage
  import tims_mem_pkg::*;
(
  input  wire                clk,
  input  wire                i_reset,
  input  wire                i_valid,
  input  decoded_req_t       i_dreq,
  output logic               o_ext_req,
  output ext_req_t           o_ext_req_data,
  input  wire                i_ext_ack,
  input  wire [DATA_W-1:0]   i_ext_rdata,
  output logic               o_done,
  output logic [DATA_W-1:0]  o_rdata,
  output logic               o_timeout
);

  logic                  w_pad_sel;
  logic                  w_ext_start;
  logic [BYTE_EN_W-1:0]  w_we_lanes;
  logic [DATA_W-1:0]     w_pad_rdata;
  ext_req_t              w_ext_req;
  logic                  w_ext_done;
  logic [DATA_W-1:0]     w_ext_rdata;
  logic                  w_ext_timeout;
  logic                  r_pad_done;   // Scratchpad answer ready
  logic                  r_pad_read;
  logic                  r_none_done;  // Unmapped answer

  assign w_pad_sel   = i_valid && (i_dreq.target == TGT_PAD);
  assign w_ext_start = i_valid && (i_dreq.target == TGT_EXT);
  assign w_we_lanes  = (w_pad_sel && i_dreq.req.we) ? i_dreq.req.be : '0;

  assign w_ext_req.addr  = i_dreq.req.addr;   // Address unchanged off chip
  assign w_ext_req.wdata = i_dreq.req.wdata;
  assign w_ext_req.we    = i_dreq.req.we;
  assign w_ext_req.be    = i_dreq.req.be;

  scratchpad_ram u_scratchpad_ram (
    .clk        (clk),
    .i_addr     (i_dreq.req.addr[PAD_ADDR_W-1:0]),
    .i_wdata    (i_dreq.req.wdata),
    .i_we_lanes (w_we_lanes),
    .o_rdata    (w_pad_rdata)
  );

  ext_mem_port u_ext_mem_port (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_start        (w_ext_start),
    .i_req          (w_ext_req),
    .o_ext_req      (o_ext_req),
    .o_ext_req_data (o_ext_req_data),
    .i_ext_ack      (i_ext_ack),
    .i_ext_rdata    (i_ext_rdata),
    .o_done         (w_ext_done),
    .o_rdata        (w_ext_rdata),
    .o_timeout      (w_ext_timeout)
  );

  // On-chip and unmapped accesses finish one cycle later
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      r_pad_done  <= 1'b0;
      r_pad_read  <= 1'b0;
      r_none_done <= 1'b0;
    end
    else
    begin
      r_pad_done  <= w_pad_sel;
      r_pad_read  <= w_pad_sel && !i_dreq.req.we;
      r_none_done <= i_valid && (i_dreq.target == TGT_NONE);  // Write discarded
    end
  end

  // Merge the three completions
  assign o_done    = r_pad_done || r_none_done || w_ext_done;
  assign o_rdata   = r_pad_read ? w_pad_rdata :
                     w_ext_done ? w_ext_rdata : '0;
  assign o_timeout = w_ext_done && w_ext_timeout;

endmodule

`default_nettype wire

// ==== source/region_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module region_decode_stage
  import tims_mem_pkg::*;
(
  input  wire           clk,
  input  wire           i_reset,
  input  wire           i_valid,
  input  cpu_req_t      i_req,
  output logic          o_valid,
  output decoded_req_t  o_dreq
);

  logic [WORD_ADDR_W-1:0] w_addr;
  logic                   w_is_pad;
  logic                   w_is_rom;
  logic                   w_is_ram;
  logic                   w_is_grom;
  logic                   w_is_dsr_pi;
  logic                   w_is_paged;
  logic                   w_is_cart;
  logic                   w_is_ext;
  mem_target_t            w_target;
  cpu_req_t               w_req;

  assign w_addr = i_req.addr;

  // ===================================================================
  // Region comparisons on the word address
  // ===================================================================
  assign w_is_pad    = (w_addr[22:9] == PAD_TAG);     // 1K scratchpad
  assign w_is_rom    = (w_addr[22:12] == ROM_TAG);
  assign w_is_ram    = (w_addr[22:12] == RAM_LO_TAG)
                    || (w_addr[22:12] == RAM_A_TAG)
                    || (w_addr[22:13] == RAM_C_TAG);  // 32K expansion
  assign w_is_grom   = (w_addr[22:15] == GROM_TAG);
  assign w_is_dsr_pi = (w_addr[22:15] == DSR_PI_TAG);
  assign w_is_paged  = (w_addr[22:19] == PAGED_TAG);
  assign w_is_cart   = (w_addr[22:20] == CART_TAG_0)
                    || (w_addr[22:20] == CART_TAG_1);

  // Everything served off chip
  assign w_is_ext = w_is_rom || w_is_ram || w_is_grom || w_is_dsr_pi
                 || w_is_paged || w_is_cart;

  // Scratchpad wins over any external match
  always_comb
  begin
    if (w_is_pad)
      w_target = TGT_PAD;
    else if (w_is_ext)
      w_target = TGT_EXT;
    else
      w_target = TGT_NONE;  // Includes the 8K DSR window at 4000
  end

  // Scratchpad gets its local word address, others pass unchanged
  always_comb
  begin
    w_req = i_req;
    if (w_is_pad)
      w_req.addr = {{(WORD_ADDR_W - PAD_ADDR_W){1'b0}}, w_addr[PAD_ADDR_W-1:0]};
  end

  always_ff @(posedge clk)
  begin
    if (i_reset)
      o_valid <= 1'b0;
    else
      o_valid <= i_valid;
  end

  always_ff @(posedge clk)
  begin
    if (i_valid)
    begin
      o_dreq.req    <= w_req;
      o_dreq.target <= w_target;
    end
  end

endmodule

`default_nettype wire

// ==== source/bus_capture_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_capture_stage
  import tims_mem_pkg::*;
(
  input  wire                clk,
  input  wire                i_reset,
  input  wire                i_cpu_strobe,
  input  cpu_req_t           i_cpu_req,
  input  wire                i_done,       // Completion from access stage
  input  wire [DATA_W-1:0]   i_rdata,
  input  wire                i_timeout,
  output logic               o_valid,
  output cpu_req_t           o_req,
  output logic               o_cpu_busy,
  output logic               o_cpu_done,
  output logic [DATA_W-1:0]  o_cpu_rdata,
  output logic               o_cpu_timeout
);

  logic w_accept;  // Strobe taken only when idle

  assign w_accept = i_cpu_strobe && !o_cpu_busy;

  // Control path
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_valid       <= 1'b0;
      o_cpu_busy    <= 1'b0;
      o_cpu_done    <= 1'b0;
      o_cpu_timeout <= 1'b0;
    end
    else
    begin
      o_valid       <= w_accept;  // Strobe delayed by one cycle
      o_cpu_done    <= i_done;
      o_cpu_timeout <= i_done && i_timeout;
      if (w_accept)
        o_cpu_busy <= 1'b1;
      else if (i_done)
        o_cpu_busy <= 1'b0;       // Drops on the edge that raises done
    end
  end

  // Payload, held for the whole access
  always_ff @(posedge clk)
  begin
    if (w_accept)
      o_req <= i_cpu_req;
    o_cpu_rdata <= i_done ? i_rdata : '0;
  end

endmodule

`default_nettype wire

// ==== source/ext_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module ext_mem_port
  import tims_mem_pkg::*;
(
  input  wire                clk,
  input  wire                i_reset,
  input  wire                i_start,
  input  ext_req_t           i_req,
  output logic               o_ext_req,
  output ext_req_t           o_ext_req_data,
  input  wire                i_ext_ack,
  input  wire [DATA_W-1:0]   i_ext_rdata,
  output logic               o_done,
  output logic [DATA_W-1:0]  o_rdata,
  output logic               o_timeout
);

  typedef enum logic [1:0] {
    S_IDLE         = 2'd0,
    S_WAIT_ACK     = 2'd1,
    S_WAIT_ACK_LOW = 2'd2
  } port_state_t;

  port_state_t            r_state;
  logic                   r_pending;   // Start seen, not yet issued
  logic [WAIT_CNT_W-1:0]  r_wait_cnt;  // Wait states since req rose
  logic                   w_issue;
  logic                   w_limit;

  // Never raise req while a previous (maybe late) ack is still up
  assign w_issue = (r_state == S_IDLE) && (i_start || r_pending) && !i_ext_ack;
  assign w_limit = (r_wait_cnt == WAIT_CNT_W'(WAIT_LIMIT - 1));

  // ===================================================================
  // Four-phase handshake FSM
  // ===================================================================
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      r_state    <= S_IDLE;
      r_pending  <= 1'b0;
      r_wait_cnt <= '0;
      o_ext_req  <= 1'b0;
      o_done     <= 1'b0;
      o_timeout  <= 1'b0;
    end
    else
    begin
      o_done    <= 1'b0;      // Single-cycle pulses
      o_timeout <= 1'b0;
      if (w_issue)
        r_pending <= 1'b0;
      else if (i_start)
        r_pending <= 1'b1;    // Held until ack is low
      case (r_state)
        S_IDLE:
        begin
          if (w_issue)
          begin
            o_ext_req  <= 1'b1;
            r_wait_cnt <= '0;
            r_state    <= S_WAIT_ACK;
          end
        end
        S_WAIT_ACK:
        begin
          if (i_ext_ack)
          begin
            o_ext_req <= 1'b0;  // Phase 3
            o_done    <= 1'b1;
            r_state   <= S_WAIT_ACK_LOW;
          end
          else if (w_limit)
          begin
            o_ext_req  <= 1'b0; // Give up, answer zero
            o_done     <= 1'b1;
            o_timeout  <= 1'b1;
            r_wait_cnt <= WAIT_CNT_W'(WAIT_LIMIT);
            r_state    <= S_IDLE;
          end
          else
            r_wait_cnt <= r_wait_cnt + 1'b1;
        end
        S_WAIT_ACK_LOW:
        begin
          if (!i_ext_ack)
            r_state <= S_IDLE;  // Phase 4 seen
        end
        default: r_state <= S_IDLE;
      endcase
    end
  end

  // Request payload and captured read data
  always_ff @(posedge clk)
  begin
    if (i_start)
      o_ext_req_data <= i_req;  // Stable before req rises
    if (r_state == S_WAIT_ACK)
    begin
      if (i_ext_ack)
        o_rdata <= o_ext_req_data.we ? '0 : i_ext_rdata;  // Writes return zero
      else if (w_limit)
        o_rdata <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== source/scratchpad_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratchpad_ram
  import tims_mem_pkg::*;
(
  input  wire                   clk,
  input  wire [PAD_ADDR_W-1:0]  i_addr,
  input  wire [DATA_W-1:0]      i_wdata,
  input  wire [BYTE_EN_W-1:0]   i_we_lanes,  // One write enable per byte
  output logic [DATA_W-1:0]     o_rdata
);

  localparam int DEPTH = 1 << PAD_ADDR_W;

  // Byte wide halves so each lane writes on its own
  logic [7:0] mem_lo [DEPTH];
  logic [7:0] mem_hi [DEPTH];

  // ===================================================================
  // Low lane
  // ===================================================================
  always_ff @(posedge clk)
  begin
    if (i_we_lanes[0])
      mem_lo[i_addr] <= i_wdata[7:0];
  end

  // ===================================================================
  // High lane
  // ===================================================================
  always_ff @(posedge clk)
  begin
    if (i_we_lanes[1])
      mem_hi[i_addr] <= i_wdata[15:8];
  end

  // Synchronous read, data one cycle after the address
  always_ff @(posedge clk)
  begin
    o_rdata <= {mem_hi[i_addr], mem_lo[i_addr]};
  end

endmodule

`default_nettype wire

// ==== source/tims_mem_pkg.sv ====
`default_nettype none

package tims_mem_pkg;

  // ===================================================================
  // Bus widths
  // ===================================================================
  localparam int WORD_ADDR_W = 23;  // CPU word address
  localparam int DATA_W      = 16;
  localparam int BYTE_EN_W   = 2;   // Bit 0 low byte, bit 1 high byte
  localparam int PAD_ADDR_W  = 9;   // 512 words of scratchpad

  // Give up on external memory after this many cycles
  localparam int WAIT_LIMIT  = 100;
  localparam int WAIT_CNT_W  = $clog2(WAIT_LIMIT + 1);

  // ===================================================================
  // Region tags, compared against the top bits of the word address
  // ===================================================================
  localparam logic [13:0] PAD_TAG      = 14'b0000_0000_1000_00; // 8000..83FF
  localparam logic [10:0] ROM_TAG      = 11'h000;   // Console ROM 0000..1FFF
  localparam logic [10:0] RAM_LO_TAG   = 11'h001;   // 2000..3FFF
  localparam logic [10:0] RAM_A_TAG    = 11'h005;   // A000..BFFF
  localparam logic [9:0]  RAM_C_TAG    = 10'h003;   // C000..FFFF
  localparam logic [7:0]  GROM_TAG     = 8'h01;     // System and cart GROM
  localparam logic [7:0]  DSR_PI_TAG   = 8'h03;     // Pi interface DSR ROM
  localparam logic [3:0]  PAGED_TAG    = 4'h1;      // Paged memory, 1M..2M
  localparam logic [2:0]  CART_TAG_0   = 3'h1;      // Cartridges
  localparam logic [2:0]  CART_TAG_1   = 3'h2;

  typedef enum logic [1:0] {
    TGT_PAD  = 2'd0,
    TGT_EXT  = 2'd1,
    TGT_NONE = 2'd2
  } mem_target_t;

  // One CPU access as captured from the bus
  typedef struct packed {
    logic [WORD_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      wdata;
    logic                   we;     // 1 = write
    logic [BYTE_EN_W-1:0]   be;     // Active high lanes
  } cpu_req_t;

  typedef struct packed {
    cpu_req_t    req;
    mem_target_t target;
  } decoded_req_t;

  // What the external port shows to the memory
  typedef struct packed {
    logic [WORD_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]      wdata;
    logic                   we;
    logic [BYTE_EN_W-1:0]   be;
  } ext_req_t;

endpackage

`default_nettype wire
